//--- alu_datapath.f
+incdir+src
src/alu_pkg.sv
src/bcd_nibble.sv
src/alu_op_decode.sv
src/alu_execute.sv
src/alu_result.sv
src/alu_datapath.sv
verification/alu_datapath_assert.sv
verification/alu_datapath_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f alu_datapath.f --top-module alu_datapath_tb -o alu_sim \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/alu_sim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| { cat sim.log; echo "Simulation exited with an error"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- verification/alu_datapath_tb.sv
`include "alu_defines.svh"

module alu_datapath_tb;
	import alu_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int BP_HOLD      = 20;
	localparam int NUM_OPS      = 1 + 200 + 100 + 44 + 20 + 1;
	localparam int WATCHDOG     = NUM_OPS * 10 * 40 + RESET_CYCLES * 40;

	logic    phi2;
	logic    rst;
	logic    req;
	alu_op_t op;
	byte_t   operand;
	logic    carry_in;
	logic    decimal;
	logic    write_acc;
	logic    ack;
	byte_t   result;
	logic    acr;
	logic    avr;
	byte_t   acc;

	logic [31:0] rng_state = 32'h4b9f_24a1;
	byte_t       exp_acc = 8'h00;   // Model accumulator
	int          errors = 0;
	int          n_pass = 0;
	int          n_fail = 0;

	alu_datapath UUT (
		.phi2(phi2), .rst(rst), .req(req), .op(op), .operand(operand),
		.carry_in(carry_in), .decimal(decimal), .write_acc(write_acc),
		.ack(ack), .result(result), .acr(acr), .avr(avr), .acc(acc)
	);

	bind alu_datapath alu_datapath_assert u_check (
		.phi2(phi2), .rst(rst), .req(req), .ack(ack), .write_acc(write_acc), .acc(acc)
	);

	initial begin
		phi2 = 1'b0;
		forever #20 phi2 = ~phi2;
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic int bcd_value(input byte_t x);
		return 10 * int'(x[7:4]) + int'(x[3:0]);
	endfunction

	function automatic byte_t to_bcd(input int v);
		nibble_t hi;
		nibble_t lo;
		hi = nibble_t'(v / 10);
		lo = nibble_t'(v % 10);
		return {hi, lo};
	endfunction

	// Value checks plus bound assertion failures
	function automatic int total_errors();
		return errors + UUT.u_check.fail_count;
	endfunction

	task automatic check_val(input string name, input byte_t got, input byte_t exp);
		assert (got === exp) else begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int base);
		if (total_errors() == base) begin
			n_pass++;
			$display("Test %s: ok", name);
		end else begin
			n_fail++;
			$display("Test %s: FAILED with %0d errors", name, total_errors() - base);
		end
	endtask

	// One full four-phase transaction, hold keeps req high past ack
	task automatic do_op(input alu_op_t o, input byte_t b, input logic c, input logic d,
			input logic w, input int hold);
		byte_t      bb;
		byte_t      exp_res;
		logic       exp_acr;
		logic       exp_avr;
		logic       chk_acr;
		logic       chk_avr;
		logic [8:0] s;
		int         sv;
		int         v;
		bb = (o == `ALU_OP_SBC) ? ~b : b;   // Subtract adds the complement
		s = {1'b0, exp_acc} + {1'b0, bb} + {8'd0, c};
		sv = int'($signed(exp_acc)) + int'($signed(bb)) + (c ? 1 : 0);
		exp_res = b;
		exp_acr = 1'b0;
		exp_avr = (sv > 127) || (sv < -128);   // Outside the signed byte range
		chk_acr = 1'b0;
		chk_avr = 1'b0;
		case (o)
			`ALU_OP_ADC, `ALU_OP_SBC: begin
				exp_res = s[7:0];
				exp_acr = s[8];
				chk_acr = 1'b1;
				chk_avr = !d;   // Overflow only meaningful in binary
				if (d) begin
					v = (o == `ALU_OP_ADC) ? bcd_value(exp_acc) + bcd_value(b) + (c ? 1 : 0)
						: bcd_value(exp_acc) - bcd_value(b) - (c ? 0 : 1);
					exp_acr = (o == `ALU_OP_ADC) ? (v > 99) : (v >= 0);
					exp_res = to_bcd((v + 100) % 100);
				end
			end
			`ALU_OP_AND: exp_res = exp_acc & b;
			`ALU_OP_ORA: exp_res = exp_acc | b;
			`ALU_OP_EOR: exp_res = exp_acc ^ b;
			`ALU_OP_LSR: begin
				exp_res = {1'b0, exp_acc[7:1]};
				exp_acr = exp_acc[0];   // Shifted-out bit
				chk_acr = 1'b1;
			end
			default: exp_res = b;
		endcase
		@(posedge phi2);
		op        <= o;
		operand   <= b;
		carry_in  <= c;
		decimal   <= d;
		write_acc <= w;
		req       <= 1'b1;
		@(negedge phi2);
		while (!ack) @(negedge phi2);
		if (w) begin
			exp_acc = exp_res;
		end
		check_val("result", result, exp_res);
		check_val("acc", acc, exp_acc);
		if (chk_acr) begin
			check_val("acr", {7'd0, acr}, {7'd0, exp_acr});
		end
		if (chk_avr) begin
			check_val("avr", {7'd0, avr}, {7'd0, exp_avr});
		end
		repeat (hold) begin
			@(negedge phi2);
			check_val("ack", {7'd0, ack}, 8'd1);
			check_val("result", result, exp_res);
			check_val("acc", acc, exp_acc);
		end
		@(posedge phi2);
		req <= 1'b0;
		@(negedge phi2);
		while (ack) @(negedge phi2);
	endtask

	initial begin
		#(WATCHDOG);
		$display("Watchdog expired at %0t, the DUT stopped answering requests", $time);
		$display("Test failures found");
		$finish;
	end

	initial begin
		int          base;
		logic [31:0] r;
		rst       <= 1'b1;
		req       <= 1'b0;
		op        <= `ALU_OP_ADC;
		operand   <= 8'h00;
		carry_in  <= 1'b0;
		decimal   <= 1'b0;
		write_acc <= 1'b0;
		repeat (RESET_CYCLES) @(posedge phi2);
		rst <= 1'b0;
		@(negedge phi2);

		base = total_errors();
		check_val("result", result, 8'h00);
		check_val("acc", acc, 8'h00);
		check_val("acr", {7'd0, acr}, 8'h00);
		check_val("avr", {7'd0, avr}, 8'h00);
		check_val("ack", {7'd0, ack}, 8'h00);
		do_op(`ALU_OP_LDA, 8'h5a, 1'b0, 1'b0, 1'b1, 0);   // Latency checked by the bound module
		end_test("reset_handshake", base);

		base = total_errors();
		for (int i = 0; i < 200; i++) begin
			r = next_random();
			do_op(r[9] ? `ALU_OP_SBC : `ALU_OP_ADC, byte_t'(r), r[8], 1'b0, 1'b1, 0);
		end
		end_test("binary_add_sub", base);

		base = total_errors();
		for (int i = 0; i < 100; i++) begin
			r = next_random();
			do_op(alu_op_t'(`ALU_OP_AND + r[31:10] % 5), byte_t'(r), r[8], 1'b0, 1'b1, 0);
		end
		end_test("logic_shift", base);

		// Corner cases first, then chained BCD operations
		base = total_errors();
		do_op(`ALU_OP_LDA, 8'h99, 1'b0, 1'b0, 1'b1, 0);
		do_op(`ALU_OP_ADC, 8'h01, 1'b0, 1'b1, 1'b1, 0);
		do_op(`ALU_OP_LDA, 8'h00, 1'b0, 1'b0, 1'b1, 0);
		do_op(`ALU_OP_SBC, 8'h01, 1'b1, 1'b1, 1'b1, 0);
		for (int i = 0; i < 40; i++) begin
			r = next_random();
			do_op(r[9] ? `ALU_OP_SBC : `ALU_OP_ADC, to_bcd(int'(r[31:10] % 100)), r[8],
				1'b1, 1'b1, 0);
		end
		end_test("decimal_add_sub", base);

		base = total_errors();
		for (int i = 0; i < 20; i++) begin
			r = next_random();
			do_op(alu_op_t'(r[31:10] % 7), byte_t'(r), r[8], 1'b0, 1'b0, 0);
		end
		end_test("acc_hold", base);

		base = total_errors();
		do_op(`ALU_OP_ADC, 8'h11, 1'b1, 1'b0, 1'b1, BP_HOLD);
		end_test("back_pressure", base);

		repeat (4) @(negedge phi2);   // Let pending assertions finish
		$display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0 && total_errors() == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- verification/alu_datapath_assert.sv
module alu_datapath_assert (
	input logic           phi2,
	input logic           rst,
	input logic           req,
	input logic           ack,
	input logic           write_acc,
	input alu_pkg::byte_t acc
);
	int fail_count = 0;   // Count of failed properties

	// Every cycle after a reset edge starts with ack low
	ack_reset: assert property (@(posedge phi2) rst |=> !ack)
		else begin
			$error("ack high after a reset edge");
			fail_count++;
		end

	// Request accepted from idle, ack on the third edge after it
	ack_latency: assert property (@(posedge phi2) disable iff (rst)
		req && !ack && !$past(req) |-> ##1 !ack ##1 !ack ##1 ack)
		else begin
			$error("ack not raised exactly 3 edges after the request");
			fail_count++;
		end

	ack_release: assert property (@(posedge phi2) disable iff (rst) ack && !req |=> !ack)
		else begin
			$error("ack still high after req was sampled low");
			fail_count++;
		end

	// No write back, so acc holds through the whole operation
	acc_hold: assert property (@(posedge phi2) disable iff (rst)
		req && !ack && !$past(req) && !write_acc
		|=> $stable(acc) ##1 $stable(acc) ##1 $stable(acc))
		else begin
			$error("acc changed during an operation without write_acc");
			fail_count++;
		end

endmodule

//--- src/alu_datapath.sv
module alu_datapath (
	input  logic             phi2,
	input  logic             rst,
	input  logic             req,
	input  alu_pkg::alu_op_t op,
	input  alu_pkg::byte_t   operand,
	input  logic             carry_in,
	input  logic             decimal,
	input  logic             write_acc,
	output logic             ack,
	output alu_pkg::byte_t   result,
	output logic             acr,
	output logic             avr,
	output alu_pkg::byte_t   acc
);
	import alu_pkg::*;

	// Decode to execute
	logic  add_a_zero;
	logic  b_invert;
	logic  ands;
	logic  ors;
	logic  eors;
	logic  srs;
	logic  sums;
	logic  carry_in_q;
	logic  daa;
	logic  dsa;
	byte_t operand_q;
	logic  write_q;
	logic  valid_q;

	// Execute to result
	byte_t nres_q;
	logic  cout3_q;
	logic  acr_bin_q;
	logic  dc7_q;
	logic  avr_q;
	logic  daa_q;
	logic  dsa_q;
	logic  write_r;
	logic  valid_r;

	alu_op_decode u_decode (
		.phi2(phi2), .rst(rst), .req(req), .op(op), .operand(operand),
		.carry_in(carry_in), .decimal(decimal), .write_acc(write_acc), .ack(ack),
		.add_a_zero(add_a_zero), .b_invert(b_invert),
		.ands(ands), .ors(ors), .eors(eors), .srs(srs), .sums(sums),
		.carry_in_q(carry_in_q), .daa(daa), .dsa(dsa), .operand_q(operand_q),
		.write_q(write_q), .valid_q(valid_q)
	);

	alu_execute u_execute (
		.phi2(phi2), .rst(rst), .acc(acc), .operand_q(operand_q),
		.add_a_zero(add_a_zero), .b_invert(b_invert),
		.ands(ands), .ors(ors), .eors(eors), .srs(srs), .sums(sums),
		.carry_in_q(carry_in_q), .daa(daa), .dsa(dsa),
		.write_q(write_q), .valid_q(valid_q),
		.nres_q(nres_q), .cout3_q(cout3_q), .acr_bin_q(acr_bin_q), .dc7_q(dc7_q),
		.avr_q(avr_q), .daa_q(daa_q), .dsa_q(dsa_q),
		.write_r(write_r), .valid_r(valid_r)
	);

	alu_result u_result (
		.phi2(phi2), .rst(rst), .nres_q(nres_q), .cout3_q(cout3_q),
		.acr_bin_q(acr_bin_q), .dc7_q(dc7_q), .avr_q(avr_q),
		.daa_q(daa_q), .dsa_q(dsa_q), .write_r(write_r), .valid_r(valid_r),
		.result(result), .acr(acr), .avr(avr), .acc(acc)
	);

endmodule

//--- src/alu_result.sv
module alu_result (
	input  logic           phi2,
	input  logic           rst,
	input  alu_pkg::byte_t nres_q,
	input  logic           cout3_q,
	input  logic           acr_bin_q,
	input  logic           dc7_q,
	input  logic           avr_q,
	input  logic           daa_q,
	input  logic           dsa_q,
	input  logic           write_r,
	input  logic           valid_r,
	output alu_pkg::byte_t result,
	output logic           acr,
	output logic           avr,
	output alu_pkg::byte_t acc
);
	import alu_pkg::*;

	logic    acr_d;
	logic    daal;
	logic    dsal;
	logic    daah;
	logic    dsah;
	nibble_t adj_lo;
	nibble_t adj_hi;

	assign acr_d = acr_bin_q | dc7_q;

	// Add corrects on a digit carry, subtract on a digit borrow
	assign daal = daa_q & cout3_q;
	assign dsal = dsa_q & ~cout3_q;
	assign daah = daa_q & acr_d;
	assign dsah = dsa_q & ~acr_d;

	bcd_nibble bcd_lo (.daa(daal), .dsa(dsal), .raw(nres_q[3:0]), .adjusted(adj_lo));
	bcd_nibble bcd_hi (.daa(daah), .dsa(dsah), .raw(nres_q[7:4]), .adjusted(adj_hi));

	always_ff @(posedge phi2) begin
		if (rst) begin
			result <= '0;
			acr    <= 1'b0;
			avr    <= 1'b0;
			acc    <= '0;
		end else if (valid_r) begin
			result <= {adj_hi, adj_lo};
			acr    <= acr_d;
			avr    <= avr_q;   // Binary overflow even in decimal mode
			if (write_r) begin
				acc <= {adj_hi, adj_lo};
			end
		end
	end

endmodule

//--- src/alu_execute.sv
`include "alu_defines.svh"

module alu_execute (
	input  logic           phi2,
	input  logic           rst,
	input  alu_pkg::byte_t acc,
	input  alu_pkg::byte_t operand_q,
	input  logic           add_a_zero,
	input  logic           b_invert,
	input  logic           ands,
	input  logic           ors,
	input  logic           eors,
	input  logic           srs,
	input  logic           sums,
	input  logic           carry_in_q,
	input  logic           daa,
	input  logic           dsa,
	input  logic           write_q,
	input  logic           valid_q,
	output alu_pkg::byte_t nres_q,
	output logic           cout3_q,
	output logic           acr_bin_q,
	output logic           dc7_q,
	output logic           avr_q,
	output logic           daa_q,
	output logic           dsa_q,
	output logic           write_r,
	output logic           valid_r
);
	import alu_pkg::*;

	byte_t               ai;
	byte_t               bi;
	byte_t               and_v;
	byte_t               or_v;
	byte_t               xor_v;
	byte_t               sum_v;
	byte_t               shr_v;
	byte_t               res_v;
	logic [`ALU_WIDTH:0] carry;   // carry[i] enters bit i
	logic                dc3;
	logic                dc7;
	logic                acr_bin;
	logic                avr;

	// Adder inputs
	assign ai = add_a_zero ? '0 : acc;
	assign bi = b_invert ? ~operand_q : operand_q;

	assign and_v = ai & bi;
	assign or_v  = ai | bi;
	assign xor_v = ai ^ bi;
	assign shr_v = {1'b0, acc[`ALU_WIDTH-1:1]};   // Zero fill from the top

	// Ripple chain; a low digit above 9 forces a carry into bit 4 in decimal add
	always_comb begin
		carry[0] = carry_in_q;
		dc3      = 1'b0;
		for (int i = 0; i < `ALU_WIDTH; i++) begin
			sum_v[i]   = xor_v[i] ^ carry[i];
			carry[i+1] = and_v[i] | (or_v[i] & carry[i]);
			if (i == 3) begin
				dc3        = daa & sum_v[3] & (sum_v[2] | sum_v[1]);
				carry[i+1] = carry[i+1] | dc3;
			end
		end
	end

	// High digit 10..15, no binary carry needed
	assign dc7 = daa & sum_v[7] & (sum_v[6] | sum_v[5]);

	// Same input signs, different sum sign
	assign avr = sums & (ai[7] == bi[7]) & (sum_v[7] != ai[7]);

	assign acr_bin = sums ? carry[`ALU_WIDTH] : (srs & acc[0]);

	always_comb begin
		if (srs) begin
			res_v = shr_v;
		end else if (ands) begin
			res_v = and_v;
		end else if (ors) begin
			res_v = or_v;
		end else if (eors) begin
			res_v = xor_v;
		end else if (sums) begin
			res_v = sum_v;
		end else begin
			res_v = '0;
		end
	end

	always_ff @(posedge phi2) begin
		if (valid_q) begin
			nres_q    <= res_v;
			cout3_q   <= carry[4];   // Low digit carry, decimal part included
			acr_bin_q <= acr_bin;
			dc7_q     <= dc7;
			avr_q     <= avr;
		end
	end

	always_ff @(posedge phi2) begin
		if (rst) begin
			daa_q   <= 1'b0;
			dsa_q   <= 1'b0;
			write_r <= 1'b0;
			valid_r <= 1'b0;
		end else begin
			valid_r <= valid_q;
			if (valid_q) begin
				daa_q   <= daa;
				dsa_q   <= dsa;
				write_r <= write_q;
			end
		end
	end

endmodule

//--- src/alu_op_decode.sv
`include "alu_defines.svh"

module alu_op_decode (
	input  logic             phi2,
	input  logic             rst,
	input  logic             req,
	input  alu_pkg::alu_op_t op,
	input  alu_pkg::byte_t   operand,
	input  logic             carry_in,
	input  logic             decimal,
	input  logic             write_acc,
	output logic             ack,
	output logic             add_a_zero,
	output logic             b_invert,
	output logic             ands,
	output logic             ors,
	output logic             eors,
	output logic             srs,
	output logic             sums,
	output logic             carry_in_q,
	output logic             daa,
	output logic             dsa,
	output alu_pkg::byte_t   operand_q,
	output logic             write_q,
	output logic             valid_q
);
	import alu_pkg::*;

	hs_state_t state;
	hs_state_t state_nxt;
	logic      start;
	logic      is_adc;
	logic      is_sbc;

	assign start  = (state == HS_IDLE) && req;
	assign ack    = (state == HS_ACK);   // Held until req drops
	assign is_adc = (op == `ALU_OP_ADC);
	assign is_sbc = (op == `ALU_OP_SBC);

	// One state per pipeline stage, then wait for req low
	always_comb begin
		state_nxt = state;
		case (state)
			HS_IDLE:  if (req) state_nxt = HS_EXEC;
			HS_EXEC:  state_nxt = HS_WRITE;
			HS_WRITE: state_nxt = HS_ACK;
			HS_ACK:   if (!req) state_nxt = HS_IDLE;
			default:  state_nxt = HS_IDLE;
		endcase
	end

	always_ff @(posedge phi2) begin
		if (rst) begin
			state <= HS_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge phi2) begin
		if (rst) begin
			add_a_zero <= 1'b0;
			b_invert   <= 1'b0;
			ands       <= 1'b0;
			ors        <= 1'b0;
			eors       <= 1'b0;
			srs        <= 1'b0;
			sums       <= 1'b0;
			carry_in_q <= 1'b0;
			daa        <= 1'b0;
			dsa        <= 1'b0;
			write_q    <= 1'b0;
			valid_q    <= 1'b0;
		end else begin
			valid_q <= start;   // Pulse only on the accepting edge
			if (start) begin
				sums       <= is_adc || is_sbc;
				b_invert   <= is_sbc;              // Subtract adds the complement
				ands       <= (op == `ALU_OP_AND);
				ors        <= (op == `ALU_OP_ORA) || (op == `ALU_OP_LDA);
				eors       <= (op == `ALU_OP_EOR);
				srs        <= (op == `ALU_OP_LSR);
				add_a_zero <= (op == `ALU_OP_LDA); // 0 | operand
				daa        <= decimal && is_adc;
				dsa        <= decimal && is_sbc;
				carry_in_q <= carry_in;
				write_q    <= write_acc;
			end
		end
	end

	always_ff @(posedge phi2) begin
		if (start) begin
			operand_q <= operand;
		end
	end

endmodule

//--- src/bcd_nibble.sv
module bcd_nibble (
	input  logic             daa,
	input  logic             dsa,
	input  alu_pkg::nibble_t raw,
	output alu_pkg::nibble_t adjusted
);
	import alu_pkg::*;

	nibble_t corr;

	// Minus 6 is plus 10 modulo 16
	always_comb begin
		if (daa) begin
			corr = 4'd6;
		end else if (dsa) begin
			corr = 4'd10;
		end else begin
			corr = 4'd0;
		end
	end

	assign adjusted = raw + corr;   // Carry out of the digit dropped

endmodule

//--- src/alu_pkg.sv
`include "alu_defines.svh"

package alu_pkg;

	typedef logic [`ALU_WIDTH-1:0] byte_t;
	typedef logic [`ALU_WIDTH/2-1:0] nibble_t;   // One decimal digit lane
	typedef logic [2:0] alu_op_t;

	// Four-phase handshake sequence
	typedef enum logic [1:0] {
		HS_IDLE,
		HS_EXEC,
		HS_WRITE,
		HS_ACK
	} hs_state_t;

endpackage

//--- src/alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Datapath width in bits
`define ALU_WIDTH 8

// Operation codes
`define ALU_OP_ADC 3'd0   // Add with carry
`define ALU_OP_SBC 3'd1   // Subtract with borrow
`define ALU_OP_AND 3'd2
`define ALU_OP_ORA 3'd3
`define ALU_OP_EOR 3'd4
`define ALU_OP_LSR 3'd5   // Accumulator shift right
`define ALU_OP_LDA 3'd6   // Pass operand through OR path

`endif
